/* verilog/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int XLEN     = 32;
    localparam int NREG     = 32;
    localparam int ALU_OP_W = 12;

    // one-hot alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [XLEN-1:0]         word_t;
    typedef logic [$clog2(NREG)-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]     alu_op_t;
    typedef logic [3:0]              br_kind_t;

    localparam logic [16:0] OPC_ADD_W     = 17'h00020;  // inst[31:15]
    localparam logic [16:0] OPC_SUB_W     = 17'h00022;
    localparam logic [16:0] OPC_SLT       = 17'h00024;
    localparam logic [16:0] OPC_SLTU      = 17'h00025;
    localparam logic [16:0] OPC_NOR       = 17'h00028;
    localparam logic [16:0] OPC_AND       = 17'h00029;
    localparam logic [16:0] OPC_OR        = 17'h0002a;
    localparam logic [16:0] OPC_XOR       = 17'h0002b;
    localparam logic [16:0] OPC_SLL_W     = 17'h0002e;
    localparam logic [16:0] OPC_SRL_W     = 17'h0002f;
    localparam logic [16:0] OPC_SRA_W     = 17'h00030;
    localparam logic [16:0] OPC_SLLI_W    = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W    = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W    = 17'h00091;
    localparam logic [9:0]  OPC_SLTI      = 10'h008;    // inst[31:22]
    localparam logic [9:0]  OPC_SLTUI     = 10'h009;
    localparam logic [9:0]  OPC_ADDI_W    = 10'h00a;
    localparam logic [9:0]  OPC_ANDI      = 10'h00d;
    localparam logic [9:0]  OPC_ORI       = 10'h00e;
    localparam logic [9:0]  OPC_XORI      = 10'h00f;
    localparam logic [9:0]  OPC_LD_W      = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W      = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W   = 7'h0a;      // inst[31:25]
    localparam logic [6:0]  OPC_PCADDU12I = 7'h0e;
    localparam logic [5:0]  OPC_JIRL      = 6'h13;      // inst[31:26]
    localparam logic [5:0]  OPC_B         = 6'h14;
    localparam logic [5:0]  OPC_BL        = 6'h15;
    localparam logic [5:0]  OPC_BEQ       = 6'h16;
    localparam logic [5:0]  OPC_BNE       = 6'h17;
    localparam logic [5:0]  OPC_BLT       = 6'h18;
    localparam logic [5:0]  OPC_BGE       = 6'h19;
    localparam logic [5:0]  OPC_BLTU      = 6'h1a;
    localparam logic [5:0]  OPC_BGEU      = 6'h1b;

    // bit 3 flags a branch, [2:1] picks the compare, bit 0 inverts it
    localparam br_kind_t BR_NONE = 4'b0000;
    localparam br_kind_t BR_EQ   = 4'b1000;
    localparam br_kind_t BR_NE   = 4'b1001;
    localparam br_kind_t BR_LT   = 4'b1010;
    localparam br_kind_t BR_GE   = 4'b1011;
    localparam br_kind_t BR_LTU  = 4'b1100;
    localparam br_kind_t BR_GEU  = 4'b1101;
    localparam br_kind_t BR_JR   = 4'b1110;  // jirl
    localparam br_kind_t BR_JPC  = 4'b1111;  // b, bl

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        logic      late;  // value not ready yet
    } fwd_bus_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      rf_we;
        reg_addr_t dest;
        logic      res_from_mem;
        logic      mem_we;
        logic      need_r1;
        logic      need_r2;
        logic      src2_is_rd;
        br_kind_t  br_kind;
        word_t     br_offs;
    } decode_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     rkd_value;  // store data
        logic      rf_we;
        reg_addr_t rf_waddr;
        logic      res_from_mem;
        logic      mem_we;
        word_t     pc;
    } ex_pkt_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        logic  stall;
    } br_bus_t;

endpackage

`default_nettype wire

/* verilog/inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  word_t        inst,
    output decode_ctrl_t ctrl,
    output word_t        imm
);
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and;
    logic inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
    logic op_3r, op_cond_br, known;
    logic need_ui5, need_si12, need_si20, src2_is_4;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];
    assign i12  = inst[21:10];
    assign i16  = inst[25:10];
    assign i20  = inst[24:5];
    assign i26  = {inst[9:0], inst[25:10]};

    assign inst_add_w     = op17 == OPC_ADD_W;
    assign inst_sub_w     = op17 == OPC_SUB_W;
    assign inst_slt       = op17 == OPC_SLT;
    assign inst_sltu      = op17 == OPC_SLTU;
    assign inst_nor       = op17 == OPC_NOR;
    assign inst_and       = op17 == OPC_AND;
    assign inst_or        = op17 == OPC_OR;
    assign inst_xor       = op17 == OPC_XOR;
    assign inst_sll_w     = op17 == OPC_SLL_W;
    assign inst_srl_w     = op17 == OPC_SRL_W;
    assign inst_sra_w     = op17 == OPC_SRA_W;
    assign inst_slli_w    = op17 == OPC_SLLI_W;
    assign inst_srli_w    = op17 == OPC_SRLI_W;
    assign inst_srai_w    = op17 == OPC_SRAI_W;
    assign inst_addi_w    = op10 == OPC_ADDI_W;
    assign inst_slti      = op10 == OPC_SLTI;
    assign inst_sltui     = op10 == OPC_SLTUI;
    assign inst_andi      = op10 == OPC_ANDI;
    assign inst_ori       = op10 == OPC_ORI;
    assign inst_xori      = op10 == OPC_XORI;
    assign inst_ld_w      = op10 == OPC_LD_W;
    assign inst_st_w      = op10 == OPC_ST_W;
    assign inst_lu12i_w   = op7 == OPC_LU12I_W;
    assign inst_pcaddu12i = op7 == OPC_PCADDU12I;
    assign inst_jirl      = op6 == OPC_JIRL;
    assign inst_b         = op6 == OPC_B;
    assign inst_bl        = op6 == OPC_BL;
    assign inst_beq       = op6 == OPC_BEQ;
    assign inst_bne       = op6 == OPC_BNE;
    assign inst_blt       = op6 == OPC_BLT;
    assign inst_bge       = op6 == OPC_BGE;
    assign inst_bltu      = op6 == OPC_BLTU;
    assign inst_bgeu      = op6 == OPC_BGEU;

    assign op_3r      = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                      | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign op_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    assign need_ui5   = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12  = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_si20  = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4  = inst_jirl | inst_bl;
    assign known      = op_3r | op_cond_br | need_ui5 | need_si12 | need_si20
                      | inst_andi | inst_ori | inst_xori | inst_jirl | inst_b | inst_bl;

    always_comb begin
        ctrl = '0;  // unknown encodings fall out as a bubble
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;
        ctrl.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.src2_is_imm  = need_ui5 | need_si12 | need_si20 | src2_is_4
                          | inst_andi | inst_ori | inst_xori;
        ctrl.rf_we        = known & ~inst_st_w & ~op_cond_br & ~inst_b;
        ctrl.dest         = inst_bl ? reg_addr_t'(1) : inst[4:0];
        ctrl.res_from_mem = inst_ld_w;
        ctrl.mem_we       = inst_st_w;
        ctrl.need_r1      = known & ~inst_b & ~inst_bl & ~need_si20;
        ctrl.need_r2      = op_3r | op_cond_br | inst_st_w;
        ctrl.src2_is_rd   = op_cond_br | inst_st_w;  // rd is read, not rk
        if (inst_beq)
            ctrl.br_kind = BR_EQ;
        else if (inst_bne)
            ctrl.br_kind = BR_NE;
        else if (inst_blt)
            ctrl.br_kind = BR_LT;
        else if (inst_bge)
            ctrl.br_kind = BR_GE;
        else if (inst_bltu)
            ctrl.br_kind = BR_LTU;
        else if (inst_bgeu)
            ctrl.br_kind = BR_GEU;
        else if (inst_jirl)
            ctrl.br_kind = BR_JR;
        else if (inst_b | inst_bl)
            ctrl.br_kind = BR_JPC;
        ctrl.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b00}
                                          : {{14{i16[15]}}, i16, 2'b00};
    end

    assign imm = src2_is_4              ? word_t'(4)             :
                 need_si20              ? {i20, 12'b0}           :
                 (need_ui5 | need_si12) ? {{20{i12[11]}}, i12}   :
                                          {20'b0, i12};  // andi/ori/xori

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile import id_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);
    word_t rf [NREG];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever was written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* verilog/operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_forward import id_pkg::*; (
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      need_r1,
    input  logic      need_r2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_bus_t  ex_fwd,
    input  fwd_bus_t  mem_fwd,
    input  fwd_bus_t  wb_fwd,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      stall
);
    logic r1_ex, r1_mem, r1_wb;
    logic r2_ex, r2_mem, r2_wb;

    function automatic logic conflict(reg_addr_t addr, logic need, fwd_bus_t wr);
        return need && (addr != '0) && (addr == wr.waddr) && wr.we;
    endfunction

    assign r1_ex  = conflict(raddr1, need_r1, ex_fwd);
    assign r1_mem = conflict(raddr1, need_r1, mem_fwd);
    assign r1_wb  = conflict(raddr1, need_r1, wb_fwd);
    assign r2_ex  = conflict(raddr2, need_r2, ex_fwd);
    assign r2_mem = conflict(raddr2, need_r2, mem_fwd);
    assign r2_wb  = conflict(raddr2, need_r2, wb_fwd);

    // youngest writer wins
    assign rj_value  = r1_ex  ? ex_fwd.wdata  :
                       r1_mem ? mem_fwd.wdata :
                       r1_wb  ? wb_fwd.wdata  : rf_rdata1;
    assign rkd_value = r2_ex  ? ex_fwd.wdata  :
                       r2_mem ? mem_fwd.wdata :
                       r2_wb  ? wb_fwd.wdata  : rf_rdata2;

    assign stall = ((r1_ex | r2_ex) & ex_fwd.late)
                 | ((r1_mem | r2_mem) & mem_fwd.late);  // load still in flight

endmodule

`default_nettype wire

/* verilog/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit import id_pkg::*; (
    input  br_kind_t br_kind,
    input  word_t    br_offs,
    input  word_t    pc,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    input  logic     fire,
    input  logic     stall,
    output br_bus_t  br
);
    logic rj_eq_rd;
    logic rj_lt_rd;
    logic rj_ltu_rd;
    logic cmp;
    logic cond;

    assign rj_eq_rd  = rj_value == rkd_value;
    assign rj_lt_rd  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu_rd = rj_value < rkd_value;

    always_comb begin
        case (br_kind[2:1])
            2'b00:   cmp = rj_eq_rd;
            2'b01:   cmp = rj_lt_rd;
            2'b10:   cmp = rj_ltu_rd;
            default: cmp = 1'b1;  // jumps
        endcase
    end

    // bit 0 inverts only the compares
    assign cond = (br_kind[2:1] == 2'b11) ? 1'b1 : (cmp ^ br_kind[0]);

    assign br.taken  = br_kind[3] & cond & fire;
    assign br.target = ((br_kind == BR_JR) ? rj_value : pc) + br_offs;
    assign br.stall  = br_kind[3] & stall;

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       fetch_valid,
    input  fetch_pkt_t fetch_pkt,
    output logic       id_allowin,
    output logic       ex_valid,
    output ex_pkt_t    ex_pkt,
    input  logic       ex_allowin,
    input  fwd_bus_t   ex_fwd,
    input  fwd_bus_t   mem_fwd,
    input  fwd_bus_t   wb_fwd,
    output br_bus_t    br
);
    logic         id_valid;
    fetch_pkt_t   id_pkt;
    decode_ctrl_t ctrl;
    word_t        imm;
    reg_addr_t    rf_raddr1;
    reg_addr_t    rf_raddr2;
    word_t        rf_rdata1;
    word_t        rf_rdata2;
    word_t        rj_value;
    word_t        rkd_value;
    logic         fwd_stall;
    logic         stall;
    logic         fire;

    assign stall      = id_valid & fwd_stall;
    assign ex_valid   = id_valid & ~stall;
    assign fire       = ex_valid & ex_allowin;
    assign id_allowin = ~id_valid | fire | br.taken;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br.taken) begin
            id_valid <= 1'b0;  // drop the wrong-path fetch
        end else if (id_allowin) begin
            id_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && id_allowin) begin
            id_pkt <= fetch_pkt;
        end
    end

    inst_decoder u_dec (
        .inst (id_pkt.inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    assign rf_raddr1 = id_pkt.inst[9:5];
    assign rf_raddr2 = ctrl.src2_is_rd ? id_pkt.inst[4:0] : id_pkt.inst[14:10];

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (wb_fwd.we),
        .waddr  (wb_fwd.waddr),
        .wdata  (wb_fwd.wdata)
    );

    operand_forward u_fwd (
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .need_r1   (ctrl.need_r1),
        .need_r2   (ctrl.need_r2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (fwd_stall)
    );

    branch_unit u_br (
        .br_kind   (ctrl.br_kind),
        .br_offs   (ctrl.br_offs),
        .pc        (id_pkt.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .fire      (fire),
        .stall     (stall),
        .br        (br)
    );

    assign ex_pkt.alu_op       = ctrl.alu_op;
    assign ex_pkt.src1         = ctrl.src1_is_pc ? id_pkt.pc : rj_value;
    assign ex_pkt.src2         = ctrl.src2_is_imm ? imm : rkd_value;
    assign ex_pkt.rkd_value    = rkd_value;
    assign ex_pkt.rf_we        = ctrl.rf_we & id_valid;
    assign ex_pkt.rf_waddr     = ctrl.dest;
    assign ex_pkt.res_from_mem = ctrl.res_from_mem & id_valid;
    assign ex_pkt.mem_we       = ctrl.mem_we & id_valid;
    assign ex_pkt.pc           = id_pkt.pc;

endmodule

`default_nettype wire

/* dv/id_stage_props.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_props import id_pkg::*; (
    input logic    clk,
    input logic    resetn,
    input logic    ex_valid,
    input logic    ex_allowin,
    input br_bus_t br
);
    taken_leaves: assert property (@(posedge clk) disable iff (!resetn)
        br.taken |-> ex_valid && ex_allowin) else $error("taken branch without handshake");

    taken_then_bubble: assert property (@(posedge clk) disable iff (!resetn)
        br.taken |=> !ex_valid) else $error("instruction after taken branch reached ex");

    reset_empty: assert property (@(posedge clk)
        !resetn |=> !ex_valid) else $error("ex_valid high right after reset");

    taken_not_stalled: assert property (@(posedge clk) disable iff (!resetn)
        !(br.taken && br.stall)) else $error("branch taken while stalled");

endmodule

bind id_stage id_stage_props u_props (.*);

`default_nettype wire

/* dv/id_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage_tb import id_pkg::*; ();
    localparam int N_INST = 400;
    localparam logic [16:0] OP17 [14] = '{OPC_ADD_W, OPC_SUB_W, OPC_SLT, OPC_SLTU, OPC_NOR,
        OPC_AND, OPC_OR, OPC_XOR, OPC_SLL_W, OPC_SRL_W, OPC_SRA_W, OPC_SLLI_W, OPC_SRLI_W,
        OPC_SRAI_W};
    localparam logic [9:0] OP10 [8] = '{OPC_SLTI, OPC_SLTUI, OPC_ADDI_W, OPC_ANDI, OPC_ORI,
        OPC_XORI, OPC_LD_W, OPC_ST_W};
    localparam logic [6:0] OP7 [2] = '{OPC_LU12I_W, OPC_PCADDU12I};
    localparam logic [5:0] OP6 [9] = '{OPC_JIRL, OPC_B, OPC_BL, OPC_BEQ, OPC_BNE, OPC_BLT,
        OPC_BGE, OPC_BLTU, OPC_BGEU};

    logic       clk;
    logic       resetn;
    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       id_allowin;
    logic       ex_valid;
    ex_pkt_t    ex_pkt;
    logic       ex_allowin;
    fwd_bus_t   ex_fwd;
    fwd_bus_t   mem_fwd;
    fwd_bus_t   wb_fwd;
    br_bus_t    br;

    word_t mirror [NREG];  // expected register file contents
    logic  held;
    word_t held_inst;
    word_t held_pc;
    int    retired;

    id_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(N_INST * 40 * 20);
        $display("timeout: the stage stopped delivering instructions to ex");
        $display("TB FAILED");
        $fatal(1);
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // youngest writer wins and a late ex or mem hit stalls
    function automatic word_t operand(input reg_addr_t a, input logic need, output logic late);
        logic ex_hit;
        logic mem_hit;
        logic wb_hit;
        ex_hit  = need && a != 5'd0 && ex_fwd.we && ex_fwd.waddr == a;
        mem_hit = need && a != 5'd0 && mem_fwd.we && mem_fwd.waddr == a;
        wb_hit  = need && a != 5'd0 && wb_fwd.we && wb_fwd.waddr == a;
        late = (ex_hit && ex_fwd.late) || (mem_hit && mem_fwd.late);
        if (ex_hit)
            return ex_fwd.wdata;
        else if (mem_hit)
            return mem_fwd.wdata;
        else if (wb_hit)
            return wb_fwd.wdata;
        else if (a == 5'd0)
            return '0;
        return mirror[a];
    endfunction

    function automatic ex_pkt_t expect_pkt(input word_t inst, input word_t pc, output logic stl,
            output logic is_br, output logic tkn, output word_t tgt);
        ex_pkt_t   p;
        int        grp;  // 1 reg, 2 sext imm, 3 zext imm, 4 upper, 5 ld, 6 st, 7 cond br, 8 jirl
        int        cls;  // 1..6 compares, 7 jirl, 8 b/bl
        logic      use_pc;
        logic      s1;
        logic      s2;
        reg_addr_t r2;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     offs;
        p = '0;
        grp = 0;
        cls = 0;
        use_pc = 1'b0;
        for (int i = 0; i < 14; i++) begin
            if (inst[31:15] == OP17[i]) begin
                grp = (i < 11) ? 1 : 2;
                p.alu_op[(i < 11) ? i : i - 3] = 1'b1;
            end
        end
        // first 11 entries follow ALU bit order except nor/and swapped
        if (inst[31:15] == OPC_NOR || inst[31:15] == OPC_AND)
            p.alu_op[ALU_AND +: 2] = ~p.alu_op[ALU_AND +: 2];
        case (inst[31:22])
            OPC_SLTI, OPC_SLTUI, OPC_ADDI_W: grp = 2;
            OPC_ANDI, OPC_ORI, OPC_XORI:     grp = 3;
            OPC_LD_W:                        grp = 5;
            OPC_ST_W:                        grp = 6;
            default: ;
        endcase
        case (inst[31:22])
            OPC_SLTI:                       p.alu_op[ALU_SLT] = 1'b1;
            OPC_SLTUI:                      p.alu_op[ALU_SLTU] = 1'b1;
            OPC_ADDI_W, OPC_LD_W, OPC_ST_W: p.alu_op[ALU_ADD] = 1'b1;
            OPC_ANDI:                       p.alu_op[ALU_AND] = 1'b1;
            OPC_ORI:                        p.alu_op[ALU_OR] = 1'b1;
            OPC_XORI:                       p.alu_op[ALU_XOR] = 1'b1;
            default: ;
        endcase
        if (inst[31:25] == OPC_LU12I_W) begin
            p.alu_op[ALU_LUI] = 1'b1;
            grp = 4;
        end else if (inst[31:25] == OPC_PCADDU12I) begin
            p.alu_op[ALU_ADD] = 1'b1;
            grp = 4;
            use_pc = 1'b1;
        end
        case (inst[31:26])
            OPC_JIRL: grp = 8;
            OPC_B:    grp = 9;
            OPC_BL:   grp = 10;
            OPC_BEQ, OPC_BNE, OPC_BLT, OPC_BGE, OPC_BLTU, OPC_BGEU: grp = 7;
            default: ;
        endcase
        case (inst[31:26])
            OPC_BEQ:       cls = 1;
            OPC_BNE:       cls = 2;
            OPC_BLT:       cls = 3;
            OPC_BGE:       cls = 4;
            OPC_BLTU:      cls = 5;
            OPC_BGEU:      cls = 6;
            OPC_JIRL:      cls = 7;
            OPC_B, OPC_BL: cls = 8;
            default: ;
        endcase
        if (grp == 8 || grp == 10) begin  // link value is pc + 4
            p.alu_op[ALU_ADD] = 1'b1;
            use_pc = 1'b1;
        end
        r2 = (grp == 6 || grp == 7) ? inst[4:0] : inst[14:10];
        a = operand(inst[9:5], grp inside {1, 2, 3, 5, 6, 7, 8}, s1);
        b = operand(r2, grp inside {1, 6, 7}, s2);
        case (grp)
            2, 5, 6: imm = {{20{inst[21]}}, inst[21:10]};
            3:       imm = {20'b0, inst[21:10]};
            4:       imm = {inst[24:5], 12'b0};
            8, 10:   imm = 32'd4;
            default: imm = '0;
        endcase
        p.src1         = use_pc ? pc : a;
        p.src2         = (grp inside {2, 3, 4, 5, 6, 8, 10}) ? imm : b;
        p.rkd_value    = b;
        p.rf_we        = grp inside {1, 2, 3, 4, 5, 8, 10};
        p.rf_waddr     = (grp == 10) ? 5'd1 : inst[4:0];
        p.res_from_mem = grp == 5;
        p.mem_we       = grp == 6;
        p.pc           = pc;
        offs = (cls == 8) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                          : {{14{inst[25]}}, inst[25:10], 2'b00};
        case (cls)
            1:       tkn = a == b;
            2:       tkn = a != b;
            3:       tkn = $signed(a) < $signed(b);
            4:       tkn = $signed(a) >= $signed(b);
            5:       tkn = a < b;
            6:       tkn = a >= b;
            7, 8:    tkn = 1'b1;
            default: tkn = 1'b0;
        endcase
        is_br = cls != 0;
        tgt   = ((cls == 7) ? a : pc) + offs;
        stl   = s1 | s2;
        return p;
    endfunction

    function automatic word_t rand_inst();
        word_t     r;
        reg_addr_t rd;
        reg_addr_t rj;
        int        k;
        r  = $urandom;
        rd = reg_addr_t'($urandom % 8);  // few registers so hazards are common
        rj = reg_addr_t'($urandom % 8);
        k  = int'($urandom % 34);
        if (k < 14)
            return {OP17[k], 2'b00, r[12:10], rj, rd};
        else if (k < 22)
            return {OP10[k - 14], r[21:10], rj, rd};
        else if (k < 24)
            return {OP7[k - 22], r[24:5], rd};
        else if (k < 33)
            return {OP6[k - 24], r[25:10], rj, rd};
        return {6'h3f, r[25:0]};  // unused opcode
    endfunction

    function automatic fwd_bus_t rand_fwd(input logic can_late);
        fwd_bus_t f;
        f.we    = ($urandom % 2) == 0;
        f.waddr = reg_addr_t'($urandom % 8);
        f.wdata = $urandom;
        f.late  = can_late && ($urandom % 4) == 0;
        return f;
    endfunction

    always @(posedge clk) begin : compare
        ex_pkt_t exp;
        logic    stl;
        logic    isb;
        logic    tkn;
        word_t   tgt;
        logic    drop;
        if (!resetn) begin
            held = 1'b0;
            retired = 0;
        end else begin
            drop = 1'b0;
            if (held) begin
                exp = expect_pkt(held_inst, held_pc, stl, isb, tkn, tgt);
                check("ex_valid", word_t'(ex_valid), word_t'(!stl));
                if (stl) begin
                    check("id_allowin", word_t'(id_allowin), 32'd0);
                    check("br.stall", word_t'(br.stall), word_t'(isb));
                end
                if (ex_valid) begin
                    check("ex_pkt.alu_op", word_t'(ex_pkt.alu_op), word_t'(exp.alu_op));
                    check("ex_pkt.src1", ex_pkt.src1, exp.src1);
                    check("ex_pkt.src2", ex_pkt.src2, exp.src2);
                    check("ex_pkt.rkd_value", ex_pkt.rkd_value, exp.rkd_value);
                    check("ex_pkt.rf_we", word_t'(ex_pkt.rf_we), word_t'(exp.rf_we));
                    check("ex_pkt.rf_waddr", word_t'(ex_pkt.rf_waddr), word_t'(exp.rf_waddr));
                    check("ex_pkt.res_from_mem", word_t'(ex_pkt.res_from_mem),
                          word_t'(exp.res_from_mem));
                    check("ex_pkt.mem_we", word_t'(ex_pkt.mem_we), word_t'(exp.mem_we));
                    check("ex_pkt.pc", ex_pkt.pc, exp.pc);
                    check("br.taken", word_t'(br.taken), word_t'(tkn && ex_allowin));
                    if (tkn)
                        check("br.target", br.target, tgt);
                    check("id_allowin", word_t'(id_allowin), word_t'(ex_allowin));
                end
                if (ex_valid && ex_allowin) begin
                    held = 1'b0;
                    drop = tkn;
                    retired++;
                end
            end else begin
                check("ex_valid", word_t'(ex_valid), 32'd0);
                check("id_allowin", word_t'(id_allowin), 32'd1);
            end
            if (!drop && fetch_valid && id_allowin) begin  // wrong path dropped on taken
                held = 1'b1;
                held_inst = fetch_pkt.inst;
                held_pc = fetch_pkt.pc;
            end
            if (wb_fwd.we)
                mirror[wb_fwd.waddr] = wb_fwd.wdata;
        end
    end

    initial begin
        fetch_pkt_t fp;
        int         hold_cnt;
        void'($urandom(32'hccd3d7ab));
        resetn = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt = '0;
        ex_allowin = 1'b0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        hold_cnt = 0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 1; i < NREG; i++) begin  // fill the register file first
            @(posedge clk);
            wb_fwd <= '{we: 1'b1, waddr: reg_addr_t'(i), wdata: $urandom, late: 1'b0};
        end
        while (retired < N_INST) begin
            @(posedge clk);
            fp.inst = rand_inst();
            fp.pc = $urandom & 32'hffff_fffc;
            fetch_pkt <= fp;
            fetch_valid <= ($urandom % 4) != 0;
            if (hold_cnt > 0) begin
                ex_allowin <= 1'b0;
                hold_cnt--;
            end else begin
                ex_allowin <= 1'b1;
                if (($urandom % 8) == 0)
                    hold_cnt = int'($urandom % 6);
            end
            ex_fwd <= rand_fwd(1'b1);
            mem_fwd <= rand_fwd(1'b1);
            wb_fwd <= rand_fwd(1'b0);
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        ex_allowin <= 1'b1;
        ex_fwd <= '0;
        mem_fwd <= '0;
        wb_fwd <= '0;
        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/id_stage.sv
dv/id_stage_props.sv
dv/id_stage_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module id_stage_tb -f src.f -Mdir obj_dir
	@out="$$(./obj_dir/Vid_stage_tb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
